// ==== all.f ====
rtl/uart_frame_pkg.sv
rtl/uart_cmd_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/cmd_sequencer.sv
rtl/uart_cmd_bridge.sv
test/tb_serial_slave.sv
test/tb_uart_cmd_bridge.sv

// ==== rtl/cmd_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module cmd_sequencer #(
  parameter int BAUD_DIV  = 434,
  parameter int RESP_BITS = 32
) (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  uart_cmd_pkg::cmd_word_t              cmd_in,
  input  wire                                  cmd_vld,
  output logic                                 cmd_rdy,
  output logic [uart_frame_pkg::DATA_BITS-1:0] tx_byte,
  output logic                                 tx_start,
  input  wire                                  tx_done,
  output logic                                 rx_en,
  input  wire  [uart_frame_pkg::DATA_BITS-1:0] rx_byte,
  input  wire                                  rx_valid,
  input  wire                                  rx_bad,
  input  wire                                  rx_busy,
  output logic [uart_frame_pkg::DATA_BITS-1:0] read_data,
  output logic                                 read_rdy,
  output logic                                 read_err
);
  import uart_frame_pkg::*;
  import uart_cmd_pkg::*;

  localparam int GAP_CYC  = GAP_BITS * BAUD_DIV;
  localparam int RESP_CYC = RESP_BITS * BAUD_DIV;
  localparam int CNT_W    = $clog2((RESP_CYC > GAP_CYC) ? RESP_CYC : GAP_CYC);

  localparam logic [2:0] S_IDLE    = 3'd0,
                         S_JUDGE   = 3'd1,   // also kicks off the high byte
                         S_SEND_HI = 3'd2,
                         S_GAP     = 3'd3,
                         S_SEND_LO = 3'd4,
                         S_SEND_RD = 3'd5,
                         S_AWAIT   = 3'd6,
                         S_DONE    = 3'd7;

  logic [2:0]       state;
  logic [CNT_W-1:0] cnt;      // gap timer, then response window
  logic             rd_ok;
  cmd_word_t        cmd_q;
  logic             gap_end;
  logic             resp_end;

  assign cmd_rdy  = (state == S_IDLE);
  assign gap_end  = (state == S_GAP) && (cnt == CNT_W'(GAP_CYC - 1));
  assign resp_end = !rx_busy && (cnt == CNT_W'(RESP_CYC - 1));
  assign tx_start = (state == S_JUDGE) || gap_end;
  assign tx_byte  = (state == S_GAP) ? cmd_q.bytes[BYTE_LO] : cmd_q.bytes[BYTE_HI];
  assign rx_en    = (state == S_AWAIT);
  assign read_rdy = (state == S_DONE) && rd_ok;
  assign read_err = (state == S_DONE) && !rd_ok;

  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
      cmd_q <= cmd_in;
  end

  // ##############################
  // command FSM
  // ##############################
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= S_IDLE;
      cnt       <= '0;
      rd_ok     <= 1'b0;
      read_data <= '0;
    end
    else
    begin
      case (state)
        S_IDLE:
          if (cmd_vld)
            state <= S_JUDGE;
        S_JUDGE:
          state <= cmd_q.fields[RW_BIT] ? S_SEND_HI : S_SEND_RD;
        S_SEND_HI:
          if (tx_done)
          begin
            state <= S_GAP;
            cnt   <= '0;
          end
        S_GAP:
          if (gap_end)
            state <= S_SEND_LO;
          else
            cnt <= cnt + 1'b1;
        S_SEND_LO:
          if (tx_done)
            state <= S_IDLE;
        S_SEND_RD:
          if (tx_done)
          begin
            state <= S_AWAIT;
            cnt   <= '0;
          end
        S_AWAIT:
          if (rx_valid)
          begin
            read_data <= rx_byte;
            rd_ok     <= 1'b1;
            state     <= S_DONE;
          end
          else if (rx_bad || resp_end)
          begin
            rd_ok <= 1'b0;
            state <= S_DONE;
          end
          else if (!rx_busy)
            cnt <= cnt + 1'b1;     // frozen once a frame has started
        default:
          state <= S_IDLE;         // S_DONE puts the pulse out this cycle
      endcase
    end
  end

  a_tx_done_while_sending: assert property (@(posedge clk) disable iff (!rst_n)
    tx_done |-> (state == S_SEND_HI || state == S_SEND_LO || state == S_SEND_RD))
    else $error("tx_done while no frame was requested");

endmodule

`default_nettype wire

// ==== rtl/uart_cmd_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_cmd_bridge #(
  parameter int BAUD_DIV  = 434,
  parameter int RESP_BITS = 32
) (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire  [uart_cmd_pkg::CMD_WIDTH-1:0]   cmd_in,
  input  wire                                  cmd_vld,
  input  wire                                  rx,
  output logic                                 tx,
  output logic                                 cmd_rdy,
  output logic [uart_frame_pkg::DATA_BITS-1:0] read_data,
  output logic                                 read_rdy,
  output logic                                 read_err
);
  import uart_frame_pkg::*;

  logic [DATA_BITS-1:0] tx_byte;
  logic                 tx_start;
  logic                 tx_done;
  logic                 rx_en;
  logic [DATA_BITS-1:0] rx_byte;
  logic                 rx_valid;
  logic                 rx_bad;
  logic                 rx_busy;

  // ##############################
  // sequencer, tx and rx paths
  // ##############################
  cmd_sequencer #(
    .BAUD_DIV  (BAUD_DIV),
    .RESP_BITS (RESP_BITS)
  ) u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_byte   (tx_byte),
    .tx_start  (tx_start),
    .tx_done   (tx_done),
    .rx_en     (rx_en),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid),
    .rx_bad    (rx_bad),
    .rx_busy   (rx_busy),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_tx #(.BAUD_DIV(BAUD_DIV)) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  uart_rx #(.BAUD_DIV(BAUD_DIV)) u_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_en    (rx_en),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .rx_bad   (rx_bad),
    .rx_busy  (rx_busy)
  );

endmodule

`default_nettype wire

// ==== rtl/uart_cmd_pkg.sv ====
`default_nettype none

package uart_cmd_pkg;

  // ##############################
  // command word layout
  // ##############################

  localparam int CMD_WIDTH   = 16;
  localparam int ADDR_WIDTH  = 7;
  localparam int WDATA_WIDTH = CMD_WIDTH - 1 - ADDR_WIDTH;  // write data in the low byte

  // bit positions inside the fields view
  localparam int RW_BIT      = ADDR_WIDTH + WDATA_WIDTH;   // 1 = write, 0 = read
  localparam int ADDR_LSB    = WDATA_WIDTH;

  // high byte goes first on the line
  localparam int BYTE_HI     = 1;
  localparam int BYTE_LO     = 0;

  // same 16 bits seen two ways
  //   bytes  -> what the transmitter shifts out
  //   fields -> {rw, addr[6:0], wdata[7:0]} indexed with the constants above
  typedef union packed {
    logic [1:0][uart_frame_pkg::DATA_BITS-1:0] bytes;
    logic [CMD_WIDTH-1:0]                      fields;
  } cmd_word_t;

endpackage

`default_nettype wire

// ==== rtl/uart_frame_pkg.sv ====
`default_nettype none

package uart_frame_pkg;

  // ##############################
  // serial frame layout
  // ##############################

  // start + data + parity + stop
  localparam int DATA_BITS  = 8;
  localparam int FRAME_BITS = 11;

  // idle bit times between the two bytes of a write
  localparam int GAP_BITS   = 2;

  // ##############################
  // helpers
  // ##############################

  // parity bit that makes the count of ones even
  function automatic logic even_parity(input logic [DATA_BITS-1:0] data);
    logic par;
    par = ^data;
    return par;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/uart_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_rx #(
  parameter int BAUD_DIV = 434
) (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire                                  rx,
  input  wire                                  rx_en,
  output logic [uart_frame_pkg::DATA_BITS-1:0] rx_byte,
  output logic                                 rx_valid,
  output logic                                 rx_bad,
  output logic                                 rx_busy
);
  import uart_frame_pkg::*;

  localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
  localparam int BIT_W = $clog2(FRAME_BITS);

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_last;   // previous synced level for the falling edge
  logic [CNT_W-1:0] baud_cnt;
  logic [BIT_W-1:0] bit_cnt;
  logic             par_q;
  logic             start_edge;
  logic             sample;
  logic             frame_ok;

  assign start_edge = rx_en && !rx_busy && rx_last && !rx_sync;
  assign sample     = rx_busy && (baud_cnt == CNT_W'(BAUD_DIV / 2 - 1));   // mid-bit
  assign frame_ok   = rx_sync && (par_q == even_parity(rx_byte));

  // ##############################
  // sync, bit timing, checks
  // ##############################
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta  <= 1'b1;
      rx_sync  <= 1'b1;
      rx_last  <= 1'b1;
      rx_busy  <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
      rx_bad   <= 1'b0;
    end
    else
    begin
      rx_meta  <= rx;
      rx_sync  <= rx_meta;
      rx_last  <= rx_sync;
      rx_valid <= 1'b0;
      rx_bad   <= 1'b0;

      if (start_edge)
      begin
        rx_busy  <= 1'b1;
        baud_cnt <= '0;
        bit_cnt  <= '0;
      end
      else if (rx_busy)
      begin
        if (baud_cnt == CNT_W'(BAUD_DIV - 1))
        begin
          baud_cnt <= '0;
          bit_cnt  <= bit_cnt + 1'b1;
        end
        else
          baud_cnt <= baud_cnt + 1'b1;

        if (sample && bit_cnt == '0 && rx_sync)
          rx_busy <= 1'b0;       // glitch rather than a real start bit
        else if (sample && bit_cnt == BIT_W'(FRAME_BITS - 1))
        begin
          rx_busy  <= 1'b0;
          rx_valid <= frame_ok;
          rx_bad   <= !frame_ok;
        end
      end
    end
  end

  // data bits land LSB first, then the parity bit
  always_ff @(posedge clk)
  begin
    if (sample && bit_cnt >= BIT_W'(1) && bit_cnt <= BIT_W'(DATA_BITS))
      rx_byte <= {rx_sync, rx_byte[DATA_BITS-1:1]};
    if (sample && bit_cnt == BIT_W'(DATA_BITS + 1))
      par_q <= rx_sync;
  end

endmodule

`default_nettype wire

// ==== rtl/uart_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
  parameter int BAUD_DIV = 434
) (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire                                  tx_start,
  input  wire  [uart_frame_pkg::DATA_BITS-1:0] tx_byte,
  output logic                                 tx,
  output logic                                 tx_done
);
  import uart_frame_pkg::*;

  localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
  localparam int BIT_W = $clog2(FRAME_BITS);

  logic                 busy;
  logic [CNT_W-1:0]     baud_cnt;
  logic [BIT_W-1:0]     bit_cnt;   // 0 start, 1..8 data, 9 parity, 10 stop
  logic [DATA_BITS+1:0] shift_q;   // bits still to go with stop at the top
  logic                 bit_end;

  assign bit_end = busy && (baud_cnt == CNT_W'(BAUD_DIV - 1));
  assign tx_done = bit_end && (bit_cnt == BIT_W'(FRAME_BITS - 1));

  // ##############################
  // bit timing and line driver
  // ##############################
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx       <= 1'b1;
    end
    else if (tx_start)
    begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx       <= 1'b0;          // start bit
    end
    else if (bit_end)
    begin
      baud_cnt <= '0;
      if (bit_cnt == BIT_W'(FRAME_BITS - 1))
        busy <= 1'b0;            // line already high from the stop bit
      else
      begin
        bit_cnt <= bit_cnt + 1'b1;
        tx      <= shift_q[0];
      end
    end
    else if (busy)
      baud_cnt <= baud_cnt + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (tx_start)
      shift_q <= {1'b1, even_parity(tx_byte), tx_byte};
    else if (bit_end)
      shift_q <= {1'b1, shift_q[DATA_BITS+1:1]};
  end

  a_idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
    !busy |-> tx)
    else $error("tx low while transmitter idle");

  a_no_start_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> !busy)
    else $error("tx_start while a frame is in flight");

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_uart_cmd_bridge -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TESTS PASSED" sim.log || exit 1

// ==== test/tb_serial_slave.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_serial_slave #(
  parameter int BAUD_DIV = 8
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        line_in,     // from the bridge tx
  output logic       line_out,    // to the bridge rx
  input  wire  [1:0] resp_delay,  // answer after resp_delay + 1 bit times
  input  wire        bad_parity,
  input  wire        silent,
  output int         hi_count,
  output int         lo_count,
  output int         frame_errs,
  output logic [6:0] wr_addr,
  output logic [7:0] wr_data
);
  import uart_frame_pkg::*;

  logic [DATA_BITS-1:0] regs [128];
  logic                 rx_busy;
  logic                 want_lo;   // next frame is the low byte of a write
  int                   rx_cnt;
  int                   rx_bit;
  logic [DATA_BITS-1:0] rx_shift;
  logic                 rx_par;
  int                   wait_cnt;  // 0 when no answer is pending
  logic [DATA_BITS+1:0] tx_shift;
  logic                 tx_busy;
  int                   tx_cnt;
  int                   tx_bit;

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      line_out   <= 1'b1;
      rx_busy    <= 1'b0;
      want_lo    <= 1'b0;
      tx_busy    <= 1'b0;
      wait_cnt   <= 0;
      hi_count   <= 0;
      lo_count   <= 0;
      frame_errs <= 0;
      wr_addr    <= '0;
      wr_data    <= '0;
      for (int i = 0; i < 128; i++)
        regs[i] <= '0;
    end
    else
    begin
      // ##############################
      // receive side
      // ##############################
      if (!rx_busy && !line_in)
      begin
        rx_busy <= 1'b1;
        rx_cnt  <= 1;                // this edge is the first cycle of the start bit
        rx_bit  <= 0;
      end
      else if (rx_busy)
      begin
        rx_cnt <= (rx_cnt == BAUD_DIV - 1) ? 0 : rx_cnt + 1;
        if (rx_cnt == BAUD_DIV - 1)
          rx_bit <= rx_bit + 1;
        if (rx_cnt == BAUD_DIV / 2)
        begin
          if (rx_bit == 0 && line_in)
          begin
            rx_busy    <= 1'b0;
            frame_errs <= frame_errs + 1;
            $display("slave: start bit went high before mid-bit");
          end
          else if (rx_bit >= 1 && rx_bit <= DATA_BITS)
            rx_shift <= {line_in, rx_shift[DATA_BITS-1:1]};
          else if (rx_bit == DATA_BITS + 1)
            rx_par <= line_in;
          else if (rx_bit == FRAME_BITS - 1)
          begin
            rx_busy <= 1'b0;
            if ((^{rx_shift, rx_par}) != 1'b0 || !line_in)
            begin
              frame_errs <= frame_errs + 1;
              $display("slave: bad frame, byte %h parity %b stop %b", rx_shift, rx_par, line_in);
            end
            if (want_lo)
            begin
              regs[wr_addr] <= rx_shift;
              wr_data       <= rx_shift;
              lo_count      <= lo_count + 1;
              want_lo       <= 1'b0;
            end
            else
            begin
              hi_count <= hi_count + 1;
              if (rx_shift[7])
              begin
                wr_addr <= rx_shift[6:0];
                want_lo <= 1'b1;
              end
              else if (!silent)
              begin
                wait_cnt <= (int'(resp_delay) + 1) * BAUD_DIV;
                tx_shift <= {1'b1, (^regs[rx_shift[6:0]]) ^ bad_parity, regs[rx_shift[6:0]]};
              end
            end
          end
        end
      end

      // ##############################
      // answer side
      // ##############################
      if (wait_cnt == 1)
      begin
        wait_cnt <= 0;
        tx_busy  <= 1'b1;
        tx_cnt   <= 0;
        tx_bit   <= 0;
        line_out <= 1'b0;            // start bit
      end
      else if (wait_cnt > 1)
        wait_cnt <= wait_cnt - 1;
      else if (tx_busy)
      begin
        if (tx_cnt == BAUD_DIV - 1)
        begin
          tx_cnt <= 0;
          if (tx_bit == FRAME_BITS - 1)
            tx_busy <= 1'b0;
          else
          begin
            tx_bit   <= tx_bit + 1;
            line_out <= tx_shift[0];
            tx_shift <= {1'b1, tx_shift[DATA_BITS+1:1]};
          end
        end
        else
          tx_cnt <= tx_cnt + 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_uart_cmd_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_uart_cmd_bridge;
  import uart_cmd_pkg::*;

  localparam int BAUD_DIV  = 8;
  localparam int RESP_BITS = 32;
  localparam int NUM_CMDS  = 80;
  localparam int WAIT_MAX  = 2000;   // wait limit in cycles covering a silent read

  logic                 clk;
  logic                 rst_n;
  logic [CMD_WIDTH-1:0] cmd_in;
  logic                 cmd_vld;
  logic                 bridge_tx;
  logic                 bridge_rx;
  logic                 cmd_rdy;
  logic [7:0]           read_data;
  logic                 read_rdy;
  logic                 read_err;
  logic [1:0]           slave_delay;
  logic                 slave_bad_par;
  logic                 slave_silent;
  int                   slave_hi;
  int                   slave_lo;
  int                   slave_frame_errs;
  logic [6:0]           slave_wr_addr;
  logic [7:0]           slave_wr_data;

  logic [15:0]          lfsr_state;
  logic [7:0]           model_mem [128];
  logic [7:0]           last_read;   // what read_data must hold after a failed read
  logic [6:0]           last_wr;
  int                   check_errs;
  int                   timeouts;
  int                   n_reads;
  int                   n_writes;

  uart_cmd_bridge #(
    .BAUD_DIV  (BAUD_DIV),
    .RESP_BITS (RESP_BITS)
  ) uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (bridge_rx),
    .tx        (bridge_tx),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  tb_serial_slave #(.BAUD_DIV(BAUD_DIV)) u_slave (
    .clk        (clk),
    .rst_n      (rst_n),
    .line_in    (bridge_tx),
    .line_out   (bridge_rx),
    .resp_delay (slave_delay),
    .bad_parity (slave_bad_par),
    .silent     (slave_silent),
    .hi_count   (slave_hi),
    .lo_count   (slave_lo),
    .frame_errs (slave_frame_errs),
    .wr_addr    (slave_wr_addr),
    .wr_data    (slave_wr_data)
  );

  always #2 clk = ~clk;

  // ##############################
  // helpers
  // ##############################
  task automatic tick;
    @(posedge clk);
    #1;
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic draw(input int n, output logic [15:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      val = {val[14:0], lfsr_state[0]};
    end
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      $display("ERR %s expected %0h actual %0h", name, exp, act);
      check_errs++;
    end
  endtask

  task automatic wait_ready(input string what);
    int n;
    n = 0;
    while (!cmd_rdy && n < WAIT_MAX)
    begin
      tick();
      n++;
    end
    if (!cmd_rdy)
    begin
      $display("timeout: cmd_rdy never came back after a %s", what);
      timeouts++;
    end
  endtask

  task automatic wait_read_result(output logic got);
    int n;
    n = 0;
    while (!read_rdy && !read_err && n < WAIT_MAX)
    begin
      tick();
      n++;
    end
    got = read_rdy || read_err;
    if (!got)
    begin
      $display("timeout: neither read_rdy nor read_err pulsed");
      timeouts++;
    end
  endtask

  // mode 0 normal answer, 1 corrupted parity, 2 no answer
  task automatic run_cmd(input logic rw, input logic [6:0] addr, input logic [7:0] wdata,
                         input logic [1:0] delay, input int mode);
    logic [15:0] junk;
    logic        got;
    slave_delay   = delay;
    slave_bad_par = (mode == 1);
    slave_silent  = (mode == 2);
    cmd_in  = {rw, addr, wdata};
    cmd_vld = 1'b1;
    tick();
    for (int i = 0; i < 3; i++)
    begin
      draw(16, junk);
      cmd_in = junk;                   // must be dropped while the bridge is busy
      check("cmd_rdy while busy", 0, cmd_rdy);
      tick();
    end
    cmd_vld = 1'b0;
    if (rw)
    begin
      wait_ready("write");
      check("write address at slave", addr, slave_wr_addr);
      check("write data at slave", wdata, slave_wr_data);
      model_mem[addr] = wdata;
      last_wr = addr;
      n_writes++;
    end
    else
    begin
      wait_read_result(got);
      n_reads++;
      if (got && mode == 0)
      begin
        check("read_rdy", 1, read_rdy);
        check("read_err on good answer", 0, read_err);
        check("read data", model_mem[addr], read_data);
        last_read = model_mem[addr];
      end
      else if (got)
      begin
        check(mode == 1 ? "read_err on bad parity" : "read_err on silent slave", 1, read_err);
        check("read_rdy on failed read", 0, read_rdy);
        check("read_data held", last_read, read_data);
      end
      wait_ready("read");
    end
  endtask

  // ##############################
  // test sequence
  // ##############################
  initial
  begin
    logic [15:0] r;
    logic        rw;
    logic [6:0]  addr;
    logic [7:0]  wdata;
    logic [1:0]  idle;
    logic [1:0]  delay;
    int          mode;
    clk           = 1'b0;
    rst_n         = 1'b0;
    cmd_in        = '0;
    cmd_vld       = 1'b0;
    slave_delay   = '0;
    slave_bad_par = 1'b0;
    slave_silent  = 1'b0;
    lfsr_state    = 16'd44364;
    last_read     = '0;
    last_wr       = '0;
    check_errs    = 0;
    timeouts      = 0;
    n_reads       = 0;
    n_writes      = 0;
    for (int i = 0; i < 128; i++)
      model_mem[i] = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    check("tx after reset", 1, bridge_tx);
    check("cmd_rdy after reset", 1, cmd_rdy);
    check("read_rdy after reset", 0, read_rdy);
    check("read_err after reset", 0, read_err);

    for (int i = 0; i < NUM_CMDS && timeouts == 0; i++)
    begin
      draw(1, r);
      rw = r[0] || (i < 16);           // fill some registers first
      draw(7, r);
      addr = r[6:0];
      draw(8, r);
      wdata = r[7:0];
      draw(2, r);
      idle = r[1:0];
      draw(2, r);
      delay = r[1:0];
      draw(3, r);
      mode = (r[2:0] == 3'd0) ? 1 : (r[2:0] == 3'd1) ? 2 : 0;
      draw(1, r);
      if (!rw && r[0])
        addr = last_wr;                // read back a written address
      repeat (idle) tick();
      run_cmd(rw, addr, wdata, delay, mode);
    end

    if (timeouts == 0)
    begin
      run_cmd(1'b0, last_wr, 8'h00, 2'd1, 1);
      run_cmd(1'b0, last_wr, 8'h00, 2'd0, 2);
      run_cmd(1'b0, last_wr, 8'h00, 2'd3, 0);   // normal again after the silent one
      check("high bytes at slave", n_reads + n_writes, slave_hi);
      check("low bytes at slave", n_writes, slave_lo);
    end

    $display("errors: %0d mismatches, %0d timeouts, %0d bad frames",
             check_errs, timeouts, slave_frame_errs);
    if (check_errs == 0 && timeouts == 0 && slave_frame_errs == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
